//--- sb_cfg.svh
// build-time sizes of the instruction scoreboard
// SB_NR_ENTRIES must be a power of two, since the full flag is the top
// bit of the occupancy count and the pointers wrap by overflow
`ifndef SB_CFG_SVH
`define SB_CFG_SVH

// in-flight instruction slots, power of two only
`define SB_NR_ENTRIES 8

// result ports from the functional units
`define SB_NR_WB_PORTS 2

// integer register address width, 32 registers
`define SB_REG_AW 5

// datapath width
`define SB_XLEN 32

`endif

//--- sb_instr_pkg.sv
// instruction-level types of the scoreboard
// functional unit code, decoded instruction and table entry
`include "sb_cfg.svh"

package sb_instr_pkg;

  // the table index doubles as transaction id
  typedef logic [$clog2(`SB_NR_ENTRIES)-1:0] trans_id_t;
  typedef logic [`SB_REG_AW-1:0]             reg_addr_t;
  typedef logic [`SB_XLEN-1:0]               xlen_t;

  // unit that will produce the result, NONE completes on its own
  typedef enum logic [2:0] {
    NONE   = 3'd0,
    ALU    = 3'd1,
    BRANCH = 3'd2,
    LOAD   = 3'd3,
    STORE  = 3'd4,
    MULT   = 3'd5
  } fu_t;

  // what decode hands over, 18 bits
  typedef struct packed {
    fu_t       fu;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
  } sb_decoded_t;

  // one slot as seen on the issue and commit side, 56 bits
  typedef struct packed {
    logic        issued;
    // result present
    logic        valid;
    logic        ex_valid;
    trans_id_t   trans_id;
    sb_decoded_t decoded;
    xlen_t       result;
  } sb_entry_t;

endpackage

//--- sb_port_pkg.sv
// port-level types of the scoreboard
// write-back beat and forwarded source operand

package sb_port_pkg;

  // one result beat from a functional unit, 37 bits
  typedef struct packed {
    logic                    valid;
    // slot that receives the result
    sb_instr_pkg::trans_id_t trans_id;
    // unit raised an exception for this instruction
    logic                    ex_valid;
    sb_instr_pkg::xlen_t     data;
  } sb_wb_t;

  // one operand for the issue stage, 33 bits
  typedef struct packed {
    // data is the newest in-flight value of the register
    logic                valid;
    sb_instr_pkg::xlen_t data;
  } sb_operand_t;

endpackage

//--- prio_sel.sv
// fixed-priority selector over num_in requesters
// lowest index wins, payload type is a parameter

module prio_sel #(
  parameter int unsigned num_in = 4,
  parameter type         data_t = logic
) (
  // one request bit per source
  input  logic  [num_in-1:0] req_i,
  input  data_t [num_in-1:0] data_i,
  // returned when nobody requests
  input  data_t              default_i,
  output logic               valid_o,
  output data_t              data_o
);

  // any request at all
  assign valid_o = |req_i;

  // walk from the top down so the lowest active index is written last
  always_comb begin
    data_o = default_i;
    for (int i = int'(num_in) - 1; i >= 0; i--) begin
      if (req_i[i]) begin
        data_o = data_i[i];
      end
    end
  end

endmodule

//--- sb_entry_table.sv
// circular table of in-flight instructions
// issue and commit pointers, occupancy count, write-back, commit and flush
`include "sb_cfg.svh"

module sb_entry_table (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          flush_i,
  input  sb_instr_pkg::sb_decoded_t                     decoded_i,
  input  logic                                          accept_i,
  input  sb_port_pkg::sb_wb_t [`SB_NR_WB_PORTS-1:0]     wb_i,
  input  logic                                          commit_ack_i,
  output sb_instr_pkg::sb_entry_t [`SB_NR_ENTRIES-1:0]  entries_o,
  output sb_instr_pkg::trans_id_t                       issue_id_o,
  output sb_instr_pkg::sb_entry_t                       commit_o,
  output logic                                          full_o
);

  localparam int unsigned IdW = $clog2(`SB_NR_ENTRIES);

  // one extra bit so a full table is distinguishable from an empty one
  typedef logic [IdW:0] cnt_t;

  // slot status bits
  logic [`SB_NR_ENTRIES-1:0] issued_q, issued_d;
  logic [`SB_NR_ENTRIES-1:0] valid_q, valid_d;
  logic [`SB_NR_ENTRIES-1:0] ex_q, ex_d;

  // slot payload
  sb_instr_pkg::sb_decoded_t [`SB_NR_ENTRIES-1:0] decoded_q, decoded_d;
  sb_instr_pkg::xlen_t [`SB_NR_ENTRIES-1:0]       result_q, result_d;

  sb_instr_pkg::trans_id_t issue_ptr_q, issue_ptr_d;
  sb_instr_pkg::trans_id_t commit_ptr_q, commit_ptr_d;
  cnt_t                    cnt_q, cnt_d;

  // later updates override earlier ones
  always_comb begin
    issued_d  = issued_q;
    valid_d   = valid_q;
    ex_d      = ex_q;
    decoded_d = decoded_q;
    result_d  = result_q;

    // ----------------------------------------
    // new instruction at the issue pointer
    if (accept_i) begin
      issued_d[issue_ptr_q]  = 1'b1;
      valid_d[issue_ptr_q]   = 1'b0;
      ex_d[issue_ptr_q]      = 1'b0;
      decoded_d[issue_ptr_q] = decoded_i;
    end

    // no unit attached, so the slot is done once it sits in the table
    for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
      if (issued_q[i] && decoded_q[i].fu == sb_instr_pkg::NONE) begin
        valid_d[i] = 1'b1;
      end
    end

    // ----------------------------------------
    // results, only into slots still in flight
    // late beats after a flush are dropped here
    for (int p = 0; p < `SB_NR_WB_PORTS; p++) begin
      if (wb_i[p].valid && issued_q[wb_i[p].trans_id]) begin
        valid_d[wb_i[p].trans_id]  = 1'b1;
        result_d[wb_i[p].trans_id] = wb_i[p].data;
        ex_d[wb_i[p].trans_id]     = wb_i[p].ex_valid;
      end
    end

    // ----------------------------------------
    // retire the oldest slot
    if (commit_ack_i) begin
      issued_d[commit_ptr_q] = 1'b0;
      valid_d[commit_ptr_q]  = 1'b0;
    end

    // flush drops everything in flight
    if (flush_i) begin
      issued_d = '0;
      valid_d  = '0;
      ex_d     = '0;
    end
  end

  // pointers wrap by overflow, count moves by accept minus commit
  assign issue_ptr_d  = flush_i ? '0 : issue_ptr_q + sb_instr_pkg::trans_id_t'(accept_i);
  assign commit_ptr_d = flush_i ? '0 : commit_ptr_q + sb_instr_pkg::trans_id_t'(commit_ack_i);
  assign cnt_d        = flush_i ? '0 : cnt_q + cnt_t'(accept_i) - cnt_t'(commit_ack_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issued_q     <= '0;
      valid_q      <= '0;
      ex_q         <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else begin
      issued_q     <= issued_d;
      valid_q      <= valid_d;
      ex_q         <= ex_d;
      issue_ptr_q  <= issue_ptr_d;
      commit_ptr_q <= commit_ptr_d;
      cnt_q        <= cnt_d;
    end
  end

  // payload is only read while issued is set
  always_ff @(posedge clk_i) begin
    decoded_q <= decoded_d;
    result_q  <= result_d;
  end

  // external view, trans id is the slot index
  always_comb begin
    for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
      entries_o[i].issued   = issued_q[i];
      entries_o[i].valid    = valid_q[i];
      entries_o[i].ex_valid = ex_q[i];
      entries_o[i].trans_id = sb_instr_pkg::trans_id_t'(i);
      entries_o[i].decoded  = decoded_q[i];
      entries_o[i].result   = result_q[i];
    end
  end

  assign commit_o   = entries_o[commit_ptr_q];
  assign issue_id_o = issue_ptr_q;
  // top count bit is set exactly at 8 in flight
  assign full_o     = cnt_q[IdW];

endmodule

//--- sb_clobber.sv
// per-register clobber lookup
// reports the unit that will write each integer register, NONE if free
`include "sb_cfg.svh"

module sb_clobber (
  input  sb_instr_pkg::sb_entry_t [`SB_NR_ENTRIES-1:0] entries_i,
  output sb_instr_pkg::fu_t [2**`SB_REG_AW-1:0]        rd_clobber_o
);

  // unit code of every slot, shared by all register selectors
  sb_instr_pkg::fu_t [`SB_NR_ENTRIES-1:0] entry_fu;

  for (genvar i = 0; i < `SB_NR_ENTRIES; i++) begin : gen_fu
    assign entry_fu[i] = entries_i[i].decoded.fu;
  end

  for (genvar r = 0; r < 2**`SB_REG_AW; r++) begin : gen_reg
    logic [`SB_NR_ENTRIES-1:0] req;

    // every in-flight slot targeting this register asks
    // x0 never asks, so it falls back to NONE
    for (genvar i = 0; i < `SB_NR_ENTRIES; i++) begin : gen_req
      assign req[i] = (r != 0) && entries_i[i].issued &&
                      (entries_i[i].decoded.rd == sb_instr_pkg::reg_addr_t'(r));
    end

    // lowest slot index wins
    prio_sel #(
      .num_in (`SB_NR_ENTRIES),
      .data_t (sb_instr_pkg::fu_t)
    ) i_sel_clobber (
      .req_i     (req),
      .data_i    (entry_fu),
      .default_i (sb_instr_pkg::NONE),
      .valid_o   (),
      .data_o    (rd_clobber_o[r])
    );
  end

endmodule

//--- sb_forward.sv
// operand forwarding for two source registers
// sources are the write-back ports first, then completed table slots
`include "sb_cfg.svh"

module sb_forward (
  input  sb_instr_pkg::sb_entry_t [`SB_NR_ENTRIES-1:0] entries_i,
  input  sb_port_pkg::sb_wb_t [`SB_NR_WB_PORTS-1:0]    wb_i,
  input  sb_instr_pkg::reg_addr_t                      rs1_addr_i,
  input  sb_instr_pkg::reg_addr_t                      rs2_addr_i,
  output sb_port_pkg::sb_operand_t                     rs1_o,
  output sb_port_pkg::sb_operand_t                     rs2_o
);

  localparam int unsigned NrSrc = `SB_NR_WB_PORTS + `SB_NR_ENTRIES;

  // per source: data, destination register, able to forward
  sb_instr_pkg::xlen_t [NrSrc-1:0]     src_data;
  sb_instr_pkg::reg_addr_t [NrSrc-1:0] src_rd;
  logic [NrSrc-1:0]                    src_ok;

  sb_instr_pkg::reg_addr_t [1:0]  rs_addr;
  sb_port_pkg::sb_operand_t [1:0] rs_op;

  // beats this cycle, rd comes from the slot they target
  // an exception beat carries no usable data
  for (genvar p = 0; p < `SB_NR_WB_PORTS; p++) begin : gen_wb_src
    assign src_data[p] = wb_i[p].data;
    assign src_rd[p]   = entries_i[wb_i[p].trans_id].decoded.rd;
    assign src_ok[p]   = wb_i[p].valid & ~wb_i[p].ex_valid;
  end

  // slots that already hold their result
  for (genvar e = 0; e < `SB_NR_ENTRIES; e++) begin : gen_entry_src
    assign src_data[`SB_NR_WB_PORTS+e] = entries_i[e].result;
    assign src_rd[`SB_NR_WB_PORTS+e]   = entries_i[e].decoded.rd;
    assign src_ok[`SB_NR_WB_PORTS+e]   = entries_i[e].issued & entries_i[e].valid;
  end

  assign rs_addr[0] = rs1_addr_i;
  assign rs_addr[1] = rs2_addr_i;

  // one selector per source operand
  for (genvar s = 0; s < 2; s++) begin : gen_rs
    logic [NrSrc-1:0]    req;
    logic                hit;
    sb_instr_pkg::xlen_t data;

    for (genvar k = 0; k < NrSrc; k++) begin : gen_req
      assign req[k] = src_ok[k] && (src_rd[k] == rs_addr[s]);
    end

    prio_sel #(
      .num_in (NrSrc),
      .data_t (sb_instr_pkg::xlen_t)
    ) i_sel_rs (
      .req_i     (req),
      .data_i    (src_data),
      .default_i ('0),
      .valid_o   (hit),
      .data_o    (data)
    );

    // x0 reads the register file, never a forwarded value
    assign rs_op[s] = {hit && (rs_addr[s] != '0), data};
  end

  assign rs1_o = rs_op[0];
  assign rs2_o = rs_op[1];

endmodule

//--- scoreboard.sv
// scoreboard top level
// issue handshake, entry table, clobber lookup and operand forwarding
`include "sb_cfg.svh"

module scoreboard (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     flush_i,
  input  logic                                     unresolved_branch_i,
  // from decode
  input  sb_instr_pkg::sb_decoded_t                decoded_i,
  input  logic                                     decoded_valid_i,
  output logic                                     decoded_ack_o,
  // to issue
  output sb_instr_pkg::sb_entry_t                  issue_instr_o,
  output logic                                     issue_valid_o,
  input  logic                                     issue_ack_i,
  // functional unit results
  input  sb_port_pkg::sb_wb_t [`SB_NR_WB_PORTS-1:0] wb_i,
  // oldest instruction to commit
  output sb_instr_pkg::sb_entry_t                  commit_o,
  input  logic                                     commit_ack_i,
  // operand read, register file style
  input  sb_instr_pkg::reg_addr_t                  rs1_addr_i,
  input  sb_instr_pkg::reg_addr_t                  rs2_addr_i,
  output sb_port_pkg::sb_operand_t                 rs1_o,
  output sb_port_pkg::sb_operand_t                 rs2_o,
  output sb_instr_pkg::fu_t [2**`SB_REG_AW-1:0]    rd_clobber_o,
  output logic                                     sb_full_o
);

  sb_instr_pkg::sb_entry_t [`SB_NR_ENTRIES-1:0] entries;
  sb_instr_pkg::trans_id_t                      issue_id;
  logic                                         accept;

  // ----------------------------------------
  // issue handshake, blocked while the table is full
  // a pending branch only holds back issue_valid_o
  assign decoded_ack_o = issue_ack_i & ~sb_full_o;
  assign issue_valid_o = decoded_valid_i & ~unresolved_branch_i & ~sb_full_o;
  assign accept        = decoded_valid_i & decoded_ack_o;

  // instruction tagged with the slot it will occupy
  always_comb begin
    issue_instr_o          = '0;
    issue_instr_o.trans_id = issue_id;
    issue_instr_o.decoded  = decoded_i;
  end

  sb_entry_table i_entry_table (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .decoded_i    (decoded_i),
    .accept_i     (accept),
    .wb_i         (wb_i),
    .commit_ack_i (commit_ack_i),
    .entries_o    (entries),
    .issue_id_o   (issue_id),
    .commit_o     (commit_o),
    .full_o       (sb_full_o)
  );

  sb_clobber i_clobber (
    .entries_i    (entries),
    .rd_clobber_o (rd_clobber_o)
  );

  sb_forward i_forward (
    .entries_i  (entries),
    .wb_i       (wb_i),
    .rs1_addr_i (rs1_addr_i),
    .rs2_addr_i (rs2_addr_i),
    .rs1_o      (rs1_o),
    .rs2_o      (rs2_o)
  );

endmodule

//--- scoreboard_asserts.sv
// bound checker for the scoreboard
// shadow ids, occupancy and per-slot rd, fu, data, concurrent assertions
`include "sb_cfg.svh"

module scoreboard_asserts (
  input logic                                     clk_i,
  input logic                                     rst_ni,
  input logic                                     flush_i,
  input logic                                     unresolved_branch_i,
  input sb_instr_pkg::sb_decoded_t                decoded_i,
  input logic                                     decoded_valid_i,
  input logic                                     decoded_ack_o,
  input sb_instr_pkg::sb_entry_t                  issue_instr_o,
  input logic                                     issue_valid_o,
  input sb_port_pkg::sb_wb_t [`SB_NR_WB_PORTS-1:0] wb_i,
  input sb_instr_pkg::sb_entry_t                  commit_o,
  input logic                                     commit_ack_i,
  input sb_instr_pkg::reg_addr_t                  rs1_addr_i,
  input sb_instr_pkg::reg_addr_t                  rs2_addr_i,
  input sb_port_pkg::sb_operand_t                 rs1_o,
  input sb_port_pkg::sb_operand_t                 rs2_o,
  input sb_instr_pkg::fu_t [2**`SB_REG_AW-1:0]    rd_clobber_o,
  input logic                                     sb_full_o
);

  // shadow pointers and in-flight count
  sb_instr_pkg::trans_id_t acc_id;
  sb_instr_pkg::trans_id_t cmt_id;
  logic [3:0]              occ;
  // shadow slot state
  logic [`SB_NR_ENTRIES-1:0]                      sh_iss;
  logic [`SB_NR_ENTRIES-1:0]                      sh_val;
  sb_instr_pkg::reg_addr_t [`SB_NR_ENTRIES-1:0]   sh_rd;
  sb_instr_pkg::fu_t [`SB_NR_ENTRIES-1:0]         sh_fu;
  sb_instr_pkg::xlen_t [`SB_NR_ENTRIES-1:0]       sh_data;
  sb_instr_pkg::fu_t [2**`SB_REG_AW-1:0]          exp_clob;
  logic                                           slot_hit;
  logic                                           accept;
  int unsigned                                    err_cnt = 0;

  assign accept = decoded_valid_i & decoded_ack_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_id  <= '0;
      cmt_id  <= '0;
      occ     <= '0;
      sh_iss  <= '0;
      sh_val  <= '0;
      sh_rd   <= '0;
      sh_fu   <= '0;
      sh_data <= '0;
    end else if (flush_i) begin
      acc_id <= '0;
      cmt_id <= '0;
      occ    <= '0;
      sh_iss <= '0;
      sh_val <= '0;
    end else begin
      if (accept) begin
        sh_iss[acc_id] <= 1'b1;
        sh_val[acc_id] <= 1'b0;
        sh_rd[acc_id]  <= decoded_i.rd;
        sh_fu[acc_id]  <= decoded_i.fu;
      end
      // no unit, done one edge after it sits in the table
      for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
        if (sh_iss[i] && sh_fu[i] == sb_instr_pkg::NONE) begin
          sh_val[i] <= 1'b1;
        end
      end
      for (int p = 0; p < `SB_NR_WB_PORTS; p++) begin
        if (wb_i[p].valid && sh_iss[wb_i[p].trans_id]) begin
          sh_val[wb_i[p].trans_id]  <= 1'b1;
          sh_data[wb_i[p].trans_id] <= wb_i[p].data;
        end
      end
      if (commit_ack_i) begin
        sh_iss[cmt_id] <= 1'b0;
        sh_val[cmt_id] <= 1'b0;
      end
      acc_id <= acc_id + sb_instr_pkg::trans_id_t'(accept);
      cmt_id <= cmt_id + sb_instr_pkg::trans_id_t'(commit_ack_i);
      occ    <= occ + 4'(accept) - 4'(commit_ack_i);
    end
  end

  // ----------------------------------------
  // expected clobbers, lowest slot wins, x0 stays NONE
  always_comb begin
    slot_hit = 1'b0;
    for (int r = 0; r < 2**`SB_REG_AW; r++) begin
      exp_clob[r] = sb_instr_pkg::NONE;
      for (int i = `SB_NR_ENTRIES - 1; i >= 0; i--) begin
        if (r != 0 && sh_iss[i] && sh_rd[i] == sb_instr_pkg::reg_addr_t'(r)) begin
          exp_clob[r] = sh_fu[i];
        end
      end
    end
    for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
      if (sh_iss[i] && sh_val[i] && sh_rd[i] == rs1_addr_i) begin
        slot_hit = 1'b1;
      end
    end
  end

  a_issue_id : assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_instr_o.trans_id == acc_id)
    else begin
      $error("[FAIL] issue_instr_o.trans_id %h exp %h", issue_instr_o.trans_id, acc_id);
      err_cnt++;
    end

  a_commit_id : assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_o.trans_id == cmt_id)
    else begin
      $error("[FAIL] commit_o.trans_id %h exp %h", commit_o.trans_id, cmt_id);
      err_cnt++;
    end

  a_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    sb_full_o == (occ == 4'd8))
    else begin
      $error("[FAIL] sb_full_o %h with %h in flight", sb_full_o, occ);
      err_cnt++;
    end

  a_full_stall : assert property (@(posedge clk_i) disable iff (!rst_ni)
    sb_full_o |-> !decoded_ack_o && !issue_valid_o)
    else begin
      $error("handshake still open while the table is full");
      err_cnt++;
    end

  // covers the completion of NONE slots too
  a_done : assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_o.valid == sh_val[cmt_id])
    else begin
      $error("[FAIL] commit_o.valid %h exp %h", commit_o.valid, sh_val[cmt_id]);
      err_cnt++;
    end

  a_result : assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_ack_i && sh_fu[cmt_id] != sb_instr_pkg::NONE |->
      commit_o.result == sh_data[cmt_id])
    else begin
      $error("[FAIL] commit_o.result %h exp %h", commit_o.result, sh_data[cmt_id]);
      err_cnt++;
    end

  a_clobber : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_clobber_o == exp_clob)
    else begin
      $error("[FAIL] rd_clobber_o %h exp %h", rd_clobber_o, exp_clob);
      err_cnt++;
    end

  a_fwd : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_i[0].valid && !wb_i[0].ex_valid && sh_iss[wb_i[0].trans_id] &&
      sh_rd[wb_i[0].trans_id] == rs1_addr_i && rs1_addr_i != '0 |->
      rs1_o.valid && rs1_o.data == wb_i[0].data)
    else begin
      $error("[FAIL] rs1_o %h exp valid with data %h", rs1_o, wb_i[0].data);
      err_cnt++;
    end

  a_fwd_rs2 : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_i[0].valid && !wb_i[0].ex_valid && sh_iss[wb_i[0].trans_id] &&
      sh_rd[wb_i[0].trans_id] == rs2_addr_i && rs2_addr_i != '0 |->
      rs2_o.valid && rs2_o.data == wb_i[0].data)
    else begin
      $error("[FAIL] rs2_o %h exp valid with data %h", rs2_o, wb_i[0].data);
      err_cnt++;
    end

  // an exception beat is the only source here, nothing may forward
  a_fwd_ex : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_i[0].valid && wb_i[0].ex_valid && !wb_i[1].valid && !slot_hit &&
      sh_rd[wb_i[0].trans_id] == rs1_addr_i |-> !rs1_o.valid)
    else begin
      $error("exception beat was forwarded on rs1");
      err_cnt++;
    end

  a_x0 : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rs1_addr_i == '0 |-> !rs1_o.valid)
    else begin
      $error("read of register 0 came back valid");
      err_cnt++;
    end

  a_x0_rs2 : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rs2_addr_i == '0 |-> !rs2_o.valid)
    else begin
      $error("read of register 0 came back valid on rs2");
      err_cnt++;
    end

  a_flush : assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> !sb_full_o && issue_instr_o.trans_id == '0 && !commit_o.valid &&
      rd_clobber_o == '0)
    else begin
      $error("table not empty one cycle after flush");
      err_cnt++;
    end

  a_branch : assert property (@(posedge clk_i) disable iff (!rst_ni)
    unresolved_branch_i |-> !issue_valid_o)
    else begin
      $error("issue_valid_o high behind an unresolved branch");
      err_cnt++;
    end

  a_branch_cnt : assert property (@(posedge clk_i) disable iff (!rst_ni)
    unresolved_branch_i && !commit_ack_i && !flush_i |=> $stable(occ))
    else begin
      $error("in-flight count moved behind an unresolved branch");
      err_cnt++;
    end

endmodule

bind scoreboard scoreboard_asserts u_asserts (.*);

//--- tb_scoreboard.sv
// testbench for the scoreboard
// clock, reset, LFSR stimulus, test tasks, watchdog and final report
`include "sb_cfg.svh"

module tb_scoreboard;

  // rough cycle count of all tests, watchdog allows twice that
  localparam int TestCycles = 20 + 60 + 20 + 8;

  logic                                     clk_i;
  logic                                     rst_ni;
  logic                                     flush_i;
  logic                                     unresolved_branch_i;
  sb_instr_pkg::sb_decoded_t                decoded_i;
  logic                                     decoded_valid_i;
  logic                                     decoded_ack_o;
  sb_instr_pkg::sb_entry_t                  issue_instr_o;
  logic                                     issue_valid_o;
  logic                                     issue_ack_i;
  sb_port_pkg::sb_wb_t [`SB_NR_WB_PORTS-1:0] wb_i;
  sb_instr_pkg::sb_entry_t                  commit_o;
  logic                                     commit_ack_i;
  sb_instr_pkg::reg_addr_t                  rs1_addr_i;
  sb_instr_pkg::reg_addr_t                  rs2_addr_i;
  sb_port_pkg::sb_operand_t                 rs1_o;
  sb_port_pkg::sb_operand_t                 rs2_o;
  sb_instr_pkg::fu_t [2**`SB_REG_AW-1:0]    rd_clobber_o;
  logic                                     sb_full_o;

  logic [31:0]                                  lfsr = 32'hb6ed_06dd;
  sb_instr_pkg::fu_t [`SB_NR_ENTRIES-1:0]       fu_of;
  sb_instr_pkg::reg_addr_t [`SB_NR_ENTRIES-1:0] rd_of;
  int                                           next_id = 0;
  int                                           tb_fail = 0;
  int                                           tests = 0;

  scoreboard scoreboard_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    repeat (n) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic report(input string name);
    tests++;
    $display("test %s done, errors so far %0d", name,
             tb_fail + int'(scoreboard_i.u_asserts.err_cnt));
  endtask

  // one instruction offered with ack, random rd 1..31 and unit
  task automatic accept_one();
    logic [31:0] v;
    logic [31:0] f;
    take_bits(5, v);
    take_bits(3, f);
    decoded_i.rd  = (v[4:0] == 5'd0) ? 5'd1 : v[4:0];
    decoded_i.fu  = sb_instr_pkg::fu_t'(3'(f % 6));
    decoded_i.rs1 = v[4:0];
    decoded_i.rs2 = ~v[4:0];
    decoded_valid_i = 1'b1;
    issue_ack_i     = 1'b1;
    if (!sb_full_o) begin
      fu_of[next_id % 8] = decoded_i.fu;
      rd_of[next_id % 8] = decoded_i.rd;
      next_id++;
    end
    next_cycle();
    decoded_valid_i = 1'b0;
    issue_ack_i     = 1'b0;
  endtask

  // ALU instruction writing x0, then its result beat while both reads sit on x0
  task automatic x0_entry();
    logic [31:0] d;
    take_bits(32, d);
    decoded_i       = '{fu: sb_instr_pkg::ALU, rd: 5'd0, rs1: 5'd0, rs2: 5'd0};
    decoded_valid_i = 1'b1;
    issue_ack_i     = 1'b1;
    rs1_addr_i      = '0;
    rs2_addr_i      = '0;
    next_cycle();
    decoded_valid_i = 1'b0;
    issue_ack_i     = 1'b0;
    wb_i[0]         = '{valid: 1'b1, trans_id: 3'(next_id % 8), ex_valid: 1'b0,
                        data: d};
    next_id++;
    next_cycle();
    wb_i[0] = '0;
    next_cycle();
  endtask

  task automatic flush_all();
    flush_i = 1'b1;
    next_cycle();
    flush_i = 1'b0;
    next_id = 0;
    next_cycle();
  endtask

  // ----------------------------------------
  task automatic fill_table();
    repeat (9) accept_one();
    report("fill");
  endtask

  // result beats with forwarding reads, then in-order commit
  task automatic drain_table();
    logic [31:0] d;
    logic [31:0] e;
    int          wait_cnt;
    for (int k = 0; k < `SB_NR_ENTRIES; k++) begin
      if (fu_of[k] != sb_instr_pkg::NONE) begin
        take_bits(32, d);
        take_bits(2, e);
        wb_i[0]    = '{valid: 1'b1, trans_id: 3'(k), ex_valid: (e[1:0] == 2'd0), data: d};
        rs1_addr_i = rd_of[k];
        rs2_addr_i = rd_of[k];
        next_cycle();
        wb_i[0]    = '0;
        rs1_addr_i = '0;
        rs2_addr_i = '0;
      end
      wait_cnt = 0;
      while (!commit_o.valid && wait_cnt < 8) begin
        next_cycle();
        wait_cnt++;
      end
      if (!commit_o.valid) begin
        $display("slot %0d never became ready to commit", k);
        tb_fail++;
      end
      commit_ack_i = commit_o.valid;
      next_cycle();
      commit_ack_i = 1'b0;
    end
    report("drain");
  endtask

  // first flush hits a full table, second one a slot that holds a result
  task automatic flush_table();
    repeat (8) accept_one();
    flush_all();
    x0_entry();
    repeat (2) accept_one();
    flush_all();
    report("flush");
  endtask

  // issue stage holds its ack while the branch is open
  task automatic branch_stall();
    unresolved_branch_i = 1'b1;
    decoded_valid_i     = 1'b1;
    repeat (4) next_cycle();
    unresolved_branch_i = 1'b0;
    decoded_valid_i     = 1'b0;
    next_cycle();
    report("branch");
  endtask

  initial begin
    int errs;
    rst_ni              = 1'b0;
    flush_i             = 1'b0;
    unresolved_branch_i = 1'b0;
    decoded_i           = '0;
    decoded_valid_i     = 1'b0;
    issue_ack_i         = 1'b0;
    wb_i                = '0;
    commit_ack_i        = 1'b0;
    rs1_addr_i          = '0;
    rs2_addr_i          = '0;
    repeat (5) @(posedge clk_i);
    #2 rst_ni = 1'b1;
    next_cycle();
    fill_table();
    drain_table();
    flush_table();
    branch_stall();
    errs = tb_fail + int'(scoreboard_i.u_asserts.err_cnt);
    $display("tests %0d, failures %0d", tests, errs);
    if (errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    repeat (5 + 2 * TestCycles) @(posedge clk_i);
    $display("watchdog expired, the tests did not finish");
    $display(">>> FAIL");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+.
sb_instr_pkg.sv
sb_port_pkg.sv
prio_sel.sv
sb_entry_table.sv
sb_clobber.sv
sb_forward.sv
scoreboard.sv
scoreboard_asserts.sv
tb_scoreboard.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f --top-module tb_scoreboard || exit 1
./obj_dir/Vtb_scoreboard +verilator+error+limit+1000 \
  | awk '{ print } /^>>> PASS$/ { p = 1 } END { exit !p }' \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
